// File: Makefile
# Verilator build and run of the input-port testbench.

TOP := vc_input_port_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vc_input_port.f -o $(TOP)

# The run fails with a nonzero status when the testbench stops on $fatal.
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: hdl/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module flit_fifo (
    input  logic           clk,
    input  logic           rst,
    input  noc_pkg::flit_t data_i,
    input  logic           write_i,
    input  logic           read_i,
    output noc_pkg::flit_t data_o,
    output logic           is_full_o,
    output logic           is_empty_o,
    output logic           on_off_o
);

    localparam int DEPTH = `NOC_BUFFER_SIZE;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    noc_pkg::flit_t memory [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    // Advance a pointer by one slot and wrap at the end of the storage.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign is_full_o  = (count == CNT_W'(DEPTH));
    assign is_empty_o = (count == '0);

    // The front flit is visible without a read, one cycle after it was written.
    assign data_o = memory[rd_ptr];

    // A simultaneous read and write leave the fill count unchanged.
    always_comb
    begin
        count_next = count;
        if (write_i && !read_i)
            count_next = count + 1'b1;
        else if (read_i && !write_i)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (write_i)
            memory[wr_ptr] <= data_i;
    end

    // The on/off flag follows the next count, so it drops on the same edge
    // at which the fill level reaches the threshold. The two spare slots
    // above the threshold absorb the flits already on their way.
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            on_off_o <= 1'b1;
        end
        else
        begin
            if (write_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (read_i)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count_next;
            // Hysteresis keeps the line from toggling on every flit.
            if (count_next >= CNT_W'(`NOC_ON_OFF_LEVEL))
                on_off_o <= 1'b0;
            else if (count_next <= CNT_W'(`NOC_ON_OFF_LEVEL / 2))
                on_off_o <= 1'b1;
        end
    end

    // A sender that ignores on/off for too long would overwrite the front flit.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        write_i |-> !is_full_o);

    // The switch side must never pop a flit that was not yet stored.
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        read_i |-> !is_empty_o);

endmodule

`default_nettype wire

// File: hdl/noc_pkg.sv
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;

    //////////////////////////////
    // Flit fields
    //////////////////////////////

    // Position of a flit inside its packet.
    // A one-flit packet is marked HEADTAIL.
    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_label_t;

    // Router output directions, carried next to the head flit.
    typedef enum logic [2:0] {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    // Index of a virtual channel on either side of the router.
    typedef logic [$clog2(`NOC_VC_NUM)-1:0] vc_id_t;

    // One flit as it travels on a link, 35 bits with the default widths.
    typedef struct packed {
        flit_label_t                flit_label;
        vc_id_t                     vc_id;
        logic [`NOC_DATA_WIDTH-1:0] data;
    } flit_t;

endpackage

`default_nettype wire

// File: hdl/noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

//////////////////////////////
// Buffering
//////////////////////////////

// Flits held by each input virtual-channel buffer.
`define NOC_BUFFER_SIZE 8

// Fill count at which the on/off line to the sender goes low.
// It comes back high at half this level.
`define NOC_ON_OFF_LEVEL 6

//////////////////////////////
// Flit format
//////////////////////////////

// Virtual channels per link, the same count upstream and downstream.
`define NOC_VC_NUM 2

`define NOC_DATA_WIDTH 32

`endif

// File: hdl/output_allocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module output_allocator (
    input  logic                             clk,
    input  logic                             rst,
    input  logic           [`NOC_VC_NUM-1:0] va_req_i,
    input  logic           [`NOC_VC_NUM-1:0] sa_req_i,
    input  noc_pkg::flit_t [`NOC_VC_NUM-1:0] head_flit_i,
    input  noc_pkg::port_t [`NOC_VC_NUM-1:0] out_port_i,
    input  logic           [`NOC_VC_NUM-1:0] release_i,
    input  logic                             link_ack_i,
    output logic           [`NOC_VC_NUM-1:0] va_grant_o,
    output logic           [`NOC_VC_NUM-1:0] pop_o,
    output noc_pkg::vc_id_t                  vc_new_o,
    output logic                             link_req_o,
    output noc_pkg::flit_t                   link_flit_o,
    output noc_pkg::port_t                   link_port_o
);

    localparam int VC_NUM = `NOC_VC_NUM;

    // Four-phase master: raise req, see ack, drop req, see ack fall.
    typedef enum logic [1:0] {LINK_IDLE, LINK_REQ, LINK_WAIT_LOW, LINK_DONE} link_state_t;

    link_state_t link_state;
    link_state_t link_state_next;

    logic [VC_NUM-1:0] free_mask;
    logic [VC_NUM-1:0] free_next;
    logic [VC_NUM-1:0] release_mask;
    logic [VC_NUM-1:0] busy_mask;

    noc_pkg::vc_id_t va_ptr;
    noc_pkg::vc_id_t va_pick;
    noc_pkg::vc_id_t sa_ptr;
    noc_pkg::vc_id_t sa_pick;
    noc_pkg::vc_id_t sa_owner;

    logic va_found;
    logic free_found;
    logic sa_found;
    logic link_start;

    //////////////////////////////
    // Virtual-channel allocation
    //////////////////////////////

    // Both searches start at the round-robin pointer. The index cast wraps
    // around because the channel count is a power of two.
    always_comb
    begin
        va_found = 1'b0;
        va_pick  = va_ptr;
        sa_found = 1'b0;
        sa_pick  = sa_ptr;
        for (int i = 0; i < VC_NUM; i++)
        begin
            if (!va_found && va_req_i[noc_pkg::vc_id_t'(va_ptr + i)])
            begin
                va_found = 1'b1;
                va_pick  = noc_pkg::vc_id_t'(va_ptr + i);
            end
            if (!sa_found && sa_req_i[noc_pkg::vc_id_t'(sa_ptr + i)])
            begin
                sa_found = 1'b1;
                sa_pick  = noc_pkg::vc_id_t'(sa_ptr + i);
            end
        end

        // Lowest free downstream channel, scanned from the top down.
        free_found = 1'b0;
        vc_new_o   = '0;
        for (int i = VC_NUM - 1; i >= 0; i--)
        begin
            if (free_mask[i])
            begin
                free_found = 1'b1;
                vc_new_o   = noc_pkg::vc_id_t'(i);
            end
        end

        va_grant_o = '0;
        if (va_found && free_found)
            va_grant_o[va_pick] = 1'b1;

        // A tail being popped still shows the downstream channel it used.
        release_mask = '0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            if (release_i[i])
                release_mask[head_flit_i[i].vc_id] = 1'b1;
        end

        free_next = free_mask | release_mask;
        if (|va_grant_o)
            free_next[vc_new_o] = 1'b0;
    end

    // Downstream channels that a buffer is still forwarding on.
    always_comb
    begin
        busy_mask = '0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            if (sa_req_i[i])
                busy_mask[head_flit_i[i].vc_id] = 1'b1;
        end
    end

    //////////////////////////////
    // Switch and output link
    //////////////////////////////

    always_comb
    begin
        link_state_next = link_state;
        pop_o           = '0;
        unique case (link_state)
            // A new transfer waits until the previous ack has fallen.
            LINK_IDLE:     if (sa_found && !link_ack_i) link_state_next = LINK_REQ;
            LINK_REQ:
            begin
                if (link_ack_i)
                begin
                    pop_o[sa_owner] = 1'b1;
                    link_state_next = LINK_WAIT_LOW;
                end
            end
            LINK_WAIT_LOW: if (!link_ack_i) link_state_next = LINK_DONE;
            default:       link_state_next = LINK_IDLE;
        endcase
    end

    assign link_start = (link_state == LINK_IDLE) && (link_state_next == LINK_REQ);

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            free_mask  <= '1;
            va_ptr     <= '0;
            sa_ptr     <= '0;
            sa_owner   <= '0;
            link_state <= LINK_IDLE;
            link_req_o <= 1'b0;
        end
        else
        begin
            free_mask  <= free_next;
            link_state <= link_state_next;
            link_req_o <= (link_state_next == LINK_REQ);
            if (|va_grant_o)
                va_ptr <= va_pick + 1'b1;
            if (link_start)
                sa_owner <= sa_pick;
            // The owner of the finished transfer drops to last priority.
            if (link_state == LINK_DONE)
                sa_ptr <= sa_owner + 1'b1;
        end
    end

    // Flit and port are loaded with the request so they are stable under req.
    always_ff @(posedge clk)
    begin
        if (link_start)
        begin
            link_flit_o <= head_flit_i[sa_pick];
            link_port_o <= out_port_i[sa_pick];
        end
    end

    // A new grant must not hand out a channel that a buffer still forwards on.
    a_grant_free_vc: assert property (@(posedge clk) disable iff (rst)
        (|va_grant_o) |-> !busy_mask[vc_new_o]);

endmodule

`default_nettype wire

// File: hdl/vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vc_buffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            write_i,
    input  noc_pkg::flit_t  flit_i,
    input  noc_pkg::port_t  out_port_i,
    input  logic            va_grant_i,
    input  noc_pkg::vc_id_t vc_new_i,
    input  logic            pop_i,
    output logic            va_req_o,
    output logic            sa_req_o,
    output noc_pkg::flit_t  head_flit_o,
    output noc_pkg::port_t  out_port_o,
    output logic            release_o,
    output logic            on_off_o
);

    // Packet states: waiting for a head, waiting for a downstream channel,
    // and forwarding flits through the switch.
    typedef enum logic [1:0] {IDLE, VA, SA} state_t;

    state_t          state;
    state_t          state_next;
    noc_pkg::vc_id_t downstream_vc;
    noc_pkg::vc_id_t downstream_vc_next;
    noc_pkg::port_t  out_port_next;
    noc_pkg::flit_t  front_flit;

    logic fifo_write;
    logic fifo_read;
    logic fifo_full;
    logic fifo_empty;
    logic head_in;
    logic follow_in;
    logic last_out;

    flit_fifo u_flit_fifo (
        .clk        (clk),
        .rst        (rst),
        .data_i     (flit_i),
        .write_i    (fifo_write),
        .read_i     (fifo_read),
        .data_o     (front_flit),
        .is_full_o  (fifo_full),
        .is_empty_o (fifo_empty),
        .on_off_o   (on_off_o)
    );

    // Decode of the incoming flit and of the flit at the buffer front.
    assign head_in   = (flit_i.flit_label == noc_pkg::HEAD) ||
                       (flit_i.flit_label == noc_pkg::HEADTAIL);
    assign follow_in = (flit_i.flit_label == noc_pkg::BODY) ||
                       (flit_i.flit_label == noc_pkg::TAIL);
    assign last_out  = (front_flit.flit_label == noc_pkg::TAIL) ||
                       (front_flit.flit_label == noc_pkg::HEADTAIL);

    // The switch only sees a request when there is a flit to send.
    assign sa_req_o  = (state == SA) && !fifo_empty;
    assign fifo_read = pop_i && sa_req_o;

    always_comb
    begin
        // The forwarded flit carries the downstream channel, not the input one.
        head_flit_o.flit_label = front_flit.flit_label;
        head_flit_o.vc_id      = downstream_vc;
        head_flit_o.data       = front_flit.data;

        state_next         = state;
        out_port_next      = out_port_o;
        downstream_vc_next = downstream_vc;
        fifo_write         = 1'b0;
        va_req_o           = 1'b0;
        release_o          = 1'b0;

        unique case (state)
            IDLE:
            begin
                // A new packet starts only on a drained buffer.
                if (write_i && head_in && fifo_empty)
                begin
                    fifo_write    = 1'b1;
                    out_port_next = out_port_i;
                    state_next    = VA;
                end
            end
            VA:
            begin
                va_req_o = 1'b1;
                if (va_grant_i)
                begin
                    downstream_vc_next = vc_new_i;
                    state_next         = SA;
                end
                if (write_i && follow_in && !fifo_full)
                    fifo_write = 1'b1;
            end
            SA:
            begin
                // Popping the last flit frees the downstream channel.
                if (fifo_read && last_out)
                begin
                    release_o  = 1'b1;
                    state_next = IDLE;
                end
                if (write_i && follow_in && !fifo_full)
                    fifo_write = 1'b1;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state         <= IDLE;
            downstream_vc <= '0;
            out_port_o    <= noc_pkg::LOCAL;
        end
        else
        begin
            state         <= state_next;
            downstream_vc <= downstream_vc_next;
            out_port_o    <= out_port_next;
        end
    end

    // The allocator may only pop a channel that is asking for the switch.
    a_pop_needs_request: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> sa_req_o);

endmodule

`default_nettype wire

// File: hdl/vc_input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module vc_input_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flit_valid_i,
    input  noc_pkg::flit_t         flit_i,
    input  noc_pkg::port_t         out_port_i,
    output logic [`NOC_VC_NUM-1:0] on_off_o,
    input  logic                   link_ack_i,
    output logic                   link_req_o,
    output noc_pkg::flit_t         link_flit_o,
    output noc_pkg::port_t         link_port_o
);

    localparam int VC_NUM = `NOC_VC_NUM;

    // Per-channel wiring between the buffers and the allocator.
    logic           [VC_NUM-1:0] write_vc;
    logic           [VC_NUM-1:0] va_req;
    logic           [VC_NUM-1:0] sa_req;
    logic           [VC_NUM-1:0] va_grant;
    logic           [VC_NUM-1:0] pop;
    logic           [VC_NUM-1:0] release_vc;
    noc_pkg::flit_t [VC_NUM-1:0] head_flit;
    noc_pkg::port_t [VC_NUM-1:0] out_port;
    noc_pkg::vc_id_t             vc_new;

    for (genvar v = 0; v < VC_NUM; v++)
    begin : g_vc
        // The input channel tag of the flit selects the buffer.
        assign write_vc[v] = flit_valid_i && (flit_i.vc_id == noc_pkg::vc_id_t'(v));

        vc_buffer u_vc_buffer (
            .clk         (clk),
            .rst         (rst),
            .write_i     (write_vc[v]),
            .flit_i      (flit_i),
            .out_port_i  (out_port_i),
            .va_grant_i  (va_grant[v]),
            .vc_new_i    (vc_new),
            .pop_i       (pop[v]),
            .va_req_o    (va_req[v]),
            .sa_req_o    (sa_req[v]),
            .head_flit_o (head_flit[v]),
            .out_port_o  (out_port[v]),
            .release_o   (release_vc[v]),
            .on_off_o    (on_off_o[v])
        );
    end

    output_allocator u_output_allocator (
        .clk         (clk),
        .rst         (rst),
        .va_req_i    (va_req),
        .sa_req_i    (sa_req),
        .head_flit_i (head_flit),
        .out_port_i  (out_port),
        .release_i   (release_vc),
        .link_ack_i  (link_ack_i),
        .va_grant_o  (va_grant),
        .pop_o       (pop),
        .vc_new_o    (vc_new),
        .link_req_o  (link_req_o),
        .link_flit_o (link_flit_o),
        .link_port_o (link_port_o)
    );

endmodule

`default_nettype wire

// File: tb/vc_input_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module vc_input_port_tb;

    localparam int ROWS        = 10;
    localparam int RESET_TICKS = 10;
    localparam int STALL_TICKS = 30;

    //////////////////////////////
    // DUT signals and clock
    //////////////////////////////

    logic                   clk;
    logic                   rst;
    logic                   flit_valid;
    noc_pkg::flit_t         flit_in;
    noc_pkg::port_t         out_port;
    logic [`NOC_VC_NUM-1:0] on_off;
    logic                   link_ack;
    logic                   link_req;
    noc_pkg::flit_t         link_flit;
    noc_pkg::port_t         link_port;

    vc_input_port dut (
        .clk          (clk),
        .rst          (rst),
        .flit_valid_i (flit_valid),
        .flit_i       (flit_in),
        .out_port_i   (out_port),
        .on_off_o     (on_off),
        .link_ack_i   (link_ack),
        .link_req_o   (link_req),
        .link_flit_o  (link_flit),
        .link_port_o  (link_port)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Packet table
    //////////////////////////////

    // One row per packet: input channel, length, out port, data base and
    // whether the link responder holds off the first ack of that pair.
    // Even rows use channel 0 and odd rows channel 1, sent as pairs.
    typedef struct packed {
        noc_pkg::vc_id_t ch;
        logic [3:0]      len;
        noc_pkg::port_t  port;
        logic [31:0]     base;
        logic            stall;
    } row_t;

    row_t table_rows [ROWS];

    // Expected flits per input channel, in the order they were written.
    noc_pkg::flit_t exp_q [`NOC_VC_NUM][$];
    noc_pkg::port_t exp_port [`NOC_VC_NUM];
    noc_pkg::vc_id_t pkt_vc [`NOC_VC_NUM];
    logic [`NOC_VC_NUM-1:0] open_valid;

    integer seed = 32'he2e1_538b;
    int     sent_count;
    int     recv_count;
    int     cycle_count;
    int     cycle_limit;
    logic   stall_pending;
    logic   prev_req;
    logic   prev_ack;
    logic [`NOC_VC_NUM-1:0] off_seen;

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_flit(input string name, input noc_pkg::flit_t exp,
                              input noc_pkg::flit_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_port(input string name, input noc_pkg::port_t exp,
                              input noc_pkg::port_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_vc(input string name, input noc_pkg::vc_id_t exp,
                            input noc_pkg::vc_id_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    //////////////////////////////
    // Input driver
    //////////////////////////////

    // Label of flit k in a packet of len flits.
    function automatic noc_pkg::flit_label_t label_of(input int k, input int len);
        if (len == 1)
            return noc_pkg::HEADTAIL;
        if (k == 0)
            return noc_pkg::HEAD;
        if (k == len - 1)
            return noc_pkg::TAIL;
        return noc_pkg::BODY;
    endfunction

    task automatic add_row(input int idx, input int ch, input int len,
                           input noc_pkg::port_t port, input logic [31:0] base,
                           input logic stall);
        table_rows[idx].ch    = noc_pkg::vc_id_t'(ch);
        table_rows[idx].len   = 4'(len);
        table_rows[idx].port  = port;
        table_rows[idx].base  = base;
        table_rows[idx].stall = stall;
    endtask

    // Called 1 ns after a rising edge; returns at the same point of a later cycle.
    task automatic send_flit(input row_t row, input int k);
        noc_pkg::flit_t f;
        f.flit_label = label_of(k, int'(row.len));
        f.vc_id      = row.ch;
        f.data       = row.base + 32'(k);
        // The sender holds back while the channel signals off.
        while (!on_off[row.ch])
        begin
            flit_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        exp_q[row.ch].push_back(f);
        exp_port[row.ch] = row.port;
        flit_valid = 1'b1;
        flit_in    = f;
        out_port   = row.port;
        sent_count++;
        @(posedge clk);
        #1;
        flit_valid = 1'b0;
    endtask

    //////////////////////////////
    // Four-phase responder
    //////////////////////////////

    // Takes one flit off the link and matches it by data with the packet
    // whose next expected flit it is.
    task automatic take_flit();
        noc_pkg::flit_t  exp;
        noc_pkg::vc_id_t vc;
        int              ch;
        ch = -1;
        vc = link_flit.vc_id;
        for (int c = 0; c < `NOC_VC_NUM; c++)
            if (exp_q[c].size() > 0 && exp_q[c][0].data == link_flit.data)
                ch = c;
        if (ch < 0)
            stop_run("A flit appeared on the link that no packet expected next.");
        exp = exp_q[ch].pop_front();
        if (exp.flit_label == noc_pkg::HEAD || exp.flit_label == noc_pkg::HEADTAIL)
        begin
            if (open_valid[vc])
                stop_run("Two packets were open on the link with the same downstream channel.");
            open_valid[vc] = 1'b1;
            pkt_vc[ch]     = vc;
        end
        exp.vc_id = pkt_vc[ch];
        check_flit($sformatf("link flit of input channel %0d", ch), exp, link_flit);
        check_vc($sformatf("downstream vc of input channel %0d", ch), pkt_vc[ch], vc);
        check_port($sformatf("link port of input channel %0d", ch), exp_port[ch], link_port);
        if (exp.flit_label == noc_pkg::TAIL || exp.flit_label == noc_pkg::HEADTAIL)
            open_valid[pkt_vc[ch]] = 1'b0;
        recv_count++;
    endtask

    initial
    begin
        int delay;
        link_ack = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!link_req)
                continue;
            // A stalled pair gets one long ack delay to fill the buffers.
            if (stall_pending)
                delay = STALL_TICKS;
            else
                delay = {$random(seed)} % 6;
            stall_pending = 1'b0;
            repeat (delay)
            begin
                @(posedge clk);
                #1;
            end
            take_flit();
            link_ack = 1'b1;
            do
            begin
                @(posedge clk);
                #1;
            end
            while (link_req);
            link_ack = 1'b0;
        end
    end

    //////////////////////////////
    // Handshake watch and timeout
    //////////////////////////////

    // Request and ack have both settled by the falling edge.
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (prev_req && !link_req && !prev_ack)
                stop_run("The link request fell before the ack had risen.");
            if (!prev_req && link_req && prev_ack)
                stop_run("The link request rose again while the ack was still high.");
            off_seen = off_seen | ~on_off;
            cycle_count++;
            if (cycle_count > cycle_limit)
                stop_run("Timeout: the expected flits did not all arrive in time.");
        end
        prev_req = link_req;
        prev_ack = link_ack;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        int total;
        int max_len;
        row_t r0;
        row_t r1;
        clk           = 1'b0;
        rst           = 1'b1;
        flit_valid    = 1'b0;
        flit_in       = '0;
        out_port      = noc_pkg::LOCAL;
        sent_count    = 0;
        recv_count    = 0;
        cycle_count   = 0;
        stall_pending = 1'b0;
        prev_req      = 1'b0;
        prev_ack      = 1'b0;
        off_seen      = '0;
        open_valid    = '0;

        add_row(0, 0, 3, noc_pkg::EAST,  32'h0000_0100, 1'b0);
        add_row(1, 1, 1, noc_pkg::NORTH, 32'h0000_0200, 1'b0);
        add_row(2, 0, 5, noc_pkg::WEST,  32'h0000_0300, 1'b0);
        add_row(3, 1, 4, noc_pkg::SOUTH, 32'h0000_0400, 1'b0);
        add_row(4, 0, 1, noc_pkg::LOCAL, 32'h0000_0500, 1'b0);
        add_row(5, 1, 2, noc_pkg::EAST,  32'h0000_0600, 1'b0);
        // A long packet behind a stalled link must push on/off low.
        add_row(6, 0, 8, noc_pkg::NORTH, 32'h0000_0700, 1'b1);
        add_row(7, 1, 2, noc_pkg::WEST,  32'h0000_0800, 1'b0);
        add_row(8, 0, 2, noc_pkg::SOUTH, 32'h0000_0900, 1'b0);
        add_row(9, 1, 5, noc_pkg::LOCAL, 32'h0000_0A00, 1'b0);

        total = 0;
        for (int i = 0; i < ROWS; i++)
            total += int'(table_rows[i].len);
        cycle_limit = 40 * total + RESET_TICKS + STALL_TICKS;

        repeat (RESET_TICKS) @(posedge clk);
        #1;
        rst = 1'b0;
        if (link_req !== 1'b0)
            stop_run("The link request was not low after reset.");
        if (on_off !== '1)
            stop_run("The on/off lines were not all high after reset.");

        for (int p = 0; p < ROWS; p += 2)
        begin
            r0       = table_rows[p];
            r1       = table_rows[p + 1];
            off_seen = '0;
            if (r0.stall || r1.stall)
                stall_pending = 1'b1;
            max_len = (r0.len > r1.len) ? int'(r0.len) : int'(r1.len);
            // Flits of the two packets alternate on the input link.
            for (int k = 0; k < max_len; k++)
            begin
                if (k < int'(r0.len))
                    send_flit(r0, k);
                if (k < int'(r1.len))
                    send_flit(r1, k);
            end
            // Both buffers must be drained before their next head arrives.
            while (recv_count != sent_count)
            begin
                @(posedge clk);
                #1;
            end
            if (r0.stall && !off_seen[r0.ch])
                stop_run("On/off never fell while the link was stalled.");
            repeat (2) @(posedge clk);
            #1;
        end

        // Once every flit is delivered the link is quiet and both buffers are drained.
        if (link_req !== 1'b0 || on_off !== '1)
            stop_run("The port was not idle after the last packet.");
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vc_input_port.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/flit_fifo.sv
hdl/vc_buffer.sv
hdl/output_allocator.sv
hdl/vc_input_port.sv
tb/vc_input_port_tb.sv
